// ==== verilog/decode_pkg.sv ====
package decode_pkg;

        // Instruction word width.
        // 32 architectural bits plus 3 internal bits.
        localparam int INSTR_W = 35;

        // Link bit of a branch.
        localparam int LINK_BIT = 24;

        // Condition field position.
        localparam int COND_MSB = 31;
        localparam int COND_LSB = 28;

        // Move of PC into LR, without its condition field.
        localparam logic [COND_LSB-1:0] MOV_LR_PC = 28'h1A0E00F;

        // BL splitter states.
        typedef enum logic
        {
                S_NORMAL = 1'b0,
                S_BRANCH = 1'b1
        } bl_state_t;

        // Opcode class seen by the decoder.
        typedef enum logic [1:0]
        {
                OP_DATA   = 2'b00,
                OP_MEM    = 2'b01,
                OP_BRANCH = 2'b10,
                OP_OTHER  = 2'b11
        } op_class_t;

endpackage

// ==== verilog/bl_split_fsm.sv ====
module bl_split_fsm
(
        input  logic                           i_clk,
        input  logic                           i_reset,

        // Clears and stall, highest priority first.
        input  logic                           i_clear_from_writeback,
        input  logic                           i_clear_from_alu,
        input  logic                           i_stall_from_issue,

        // Word from the memory side.
        input  logic [decode_pkg::INSTR_W-1:0] i_instruction,
        input  logic                           i_instruction_valid,

        // Word towards the decode latch.
        output logic [decode_pkg::INSTR_W-1:0] o_instruction,
        output logic                           o_instruction_valid,

        // Freezes fetch for one cycle.
        output logic                           o_stall_from_decode,

        // Holds off interrupts during a split.
        output logic                           o_int_block
);

        import decode_pkg::*;

        bl_state_t state_ff;
        bl_state_t state_nxt;

        logic      is_bl;

        // Branch opcode with the link bit set.
        assign is_bl = i_instruction_valid &&
                       (i_instruction[27:25] == 3'b101) &&
                       i_instruction[LINK_BIT];

        always_comb
        begin
                // Default is a plain pass through.
                o_instruction       = i_instruction;
                o_instruction_valid = i_instruction_valid;
                o_stall_from_decode = 1'b0;
                o_int_block         = 1'b0;
                state_nxt           = S_NORMAL;

                case (state_ff)
                S_NORMAL:
                begin
                        if (is_bl)
                        begin
                                // First half, MOV LR, PC under the BL's condition.
                                o_instruction = {{(INSTR_W-32){1'b0}},
                                                 i_instruction[COND_MSB:COND_LSB],
                                                 MOV_LR_PC};
                                o_instruction_valid = 1'b1;

                                // Fetch must repeat the same word once.
                                o_stall_from_decode = 1'b1;
                                o_int_block         = 1'b1;
                                state_nxt           = S_BRANCH;
                        end
                end

                S_BRANCH:
                begin
                        // Second half, the branch without link.
                        o_instruction           = i_instruction;
                        o_instruction[LINK_BIT] = 1'b0;

                        // Interrupts stay off until the branch is out.
                        o_int_block = 1'b1;
                        state_nxt   = S_NORMAL;
                end

                default:
                begin
                        state_nxt = S_NORMAL;
                end
                endcase
        end

        // State advances only when nothing clears or stalls.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        state_ff <= S_NORMAL;
                else if (i_clear_from_writeback)
                        state_ff <= S_NORMAL;
                else if (i_clear_from_alu)
                        state_ff <= S_NORMAL;
                else if (i_stall_from_issue)
                        state_ff <= state_ff;
                else
                        state_ff <= state_nxt;
        end

endmodule

// ==== verilog/int_pending.sv ====
module int_pending
(
        input  logic i_clk,
        input  logic i_reset,

        // Asynchronous interrupt levels.
        input  logic i_fiq,
        input  logic i_irq,

        // CPSR mask bits, one disables.
        input  logic i_cpsr_fiq_mask,
        input  logic i_cpsr_irq_mask,

        // Resolved pending interrupts.
        output logic o_pend_fiq,
        output logic o_pend_irq
);

        // Two-stage synchronizer chains.
        logic [1:0] fiq_sync_ff;
        logic [1:0] irq_sync_ff;

        logic       fiq_unmasked;
        logic       irq_unmasked;

        // Stage 0 takes the raw level, stage 1 is the stable copy.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        fiq_sync_ff <= 2'b00;
                        irq_sync_ff <= 2'b00;
                end
                else
                begin
                        fiq_sync_ff <= {fiq_sync_ff[0], i_fiq};
                        irq_sync_ff <= {irq_sync_ff[0], i_irq};
                end
        end

        // Masking after the synchronizers.
        assign fiq_unmasked = fiq_sync_ff[1] & ~i_cpsr_fiq_mask;
        assign irq_unmasked = irq_sync_ff[1] & ~i_cpsr_irq_mask;

        // FIQ wins over IRQ.
        always_comb
        begin
                o_pend_fiq = fiq_unmasked;
                o_pend_irq = irq_unmasked & ~fiq_unmasked;
        end

endmodule

// ==== verilog/decode_latch.sv ====
module decode_latch
(
        input  logic                           i_clk,
        input  logic                           i_reset,

        // Clears and stall, highest priority first.
        input  logic                           i_clear_from_writeback,
        input  logic                           i_clear_from_alu,
        input  logic                           i_stall_from_issue,

        // Word from the BL splitter.
        input  logic [decode_pkg::INSTR_W-1:0] i_instruction,
        input  logic                           i_instruction_valid,
        input  logic                           i_int_block,

        // Resolved interrupts.
        input  logic                           i_pend_fiq,
        input  logic                           i_pend_irq,

        // Registered outputs to the decoder.
        output logic [decode_pkg::INSTR_W-1:0] o_instruction,
        output logic                           o_instruction_valid,
        output decode_pkg::op_class_t          o_op_class,
        output logic                           o_fiq,
        output logic                           o_irq
);

        import decode_pkg::*;

        op_class_t op_class_nxt;
        logic      clear;
        logic      load_payload;
        logic      fiq_nxt;
        logic      irq_nxt;

        // Either clear source.
        assign clear = i_clear_from_writeback | i_clear_from_alu;

        // Payload follows the input unless stalled.
        assign load_payload = i_reset | clear | ~i_stall_from_issue;

        // Opcode class from bits 27 to 25.
        always_comb
        begin
                case (i_instruction[27:25])
                3'b101:
                        op_class_nxt = OP_BRANCH;
                3'b010,
                3'b011:
                        op_class_nxt = OP_MEM;
                3'b000,
                3'b001:
                        op_class_nxt = OP_DATA;
                default:
                        op_class_nxt = OP_OTHER;
                endcase
        end

        // Interrupts suppressed while a split is in flight.
        assign fiq_nxt = i_pend_fiq & ~i_int_block;
        assign irq_nxt = i_pend_irq & ~i_int_block;

        // Instruction payload.
        always_ff @(posedge i_clk)
        begin
                if (load_payload)
                        o_instruction <= i_instruction;
        end

        // Control state, reset and clears first, then stall.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_instruction_valid <= 1'b0;
                        o_op_class          <= OP_OTHER;
                        o_fiq               <= 1'b0;
                        o_irq               <= 1'b0;
                end
                else if (clear)
                begin
                        // Flushed slot carries no class.
                        o_instruction_valid <= 1'b0;
                        o_op_class          <= OP_OTHER;
                        o_fiq               <= 1'b0;
                        o_irq               <= 1'b0;
                end
                else if (i_stall_from_issue)
                begin
                        // Hold everything.
                        o_instruction_valid <= o_instruction_valid;
                        o_op_class          <= o_op_class;
                        o_fiq               <= o_fiq;
                        o_irq               <= o_irq;
                end
                else
                begin
                        // Interrupts latch even without a valid word.
                        o_instruction_valid <= i_instruction_valid;
                        o_op_class          <= op_class_nxt;
                        o_fiq               <= fiq_nxt;
                        o_irq               <= irq_nxt;
                end
        end

endmodule

// ==== verilog/decode_frontend.sv ====
module decode_frontend
(
        input  logic                           i_clk,
        input  logic                           i_reset,

        // Interrupt levels and CPSR masks.
        input  logic                           i_fiq,
        input  logic                           i_irq,
        input  logic                           i_cpsr_fiq_mask,
        input  logic                           i_cpsr_irq_mask,

        // Clears and stall, highest priority first.
        input  logic                           i_clear_from_writeback,
        input  logic                           i_clear_from_alu,
        input  logic                           i_stall_from_issue,

        // Word from the memory side.
        input  logic [decode_pkg::INSTR_W-1:0] i_instruction,
        input  logic                           i_instruction_valid,

        // Towards the decoder.
        output logic [decode_pkg::INSTR_W-1:0] o_instruction,
        output logic                           o_instruction_valid,
        output decode_pkg::op_class_t          o_op_class,

        // Towards fetch.
        output logic                           o_stall_from_decode,

        // Interrupts towards the decoder.
        output logic                           o_fiq,
        output logic                           o_irq
);

        import decode_pkg::*;

        // Splitter to latch.
        logic [INSTR_W-1:0] split_instruction;
        logic               split_valid;
        logic               split_int_block;

        // Interrupt unit to latch.
        logic               pend_fiq;
        logic               pend_irq;

        // BL into MOV LR, PC plus plain branch.
        bl_split_fsm u_bl_split_fsm
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_clear_from_alu       (i_clear_from_alu),
                .i_stall_from_issue     (i_stall_from_issue),
                .i_instruction          (i_instruction),
                .i_instruction_valid    (i_instruction_valid),
                .o_instruction          (split_instruction),
                .o_instruction_valid    (split_valid),
                .o_stall_from_decode    (o_stall_from_decode),
                .o_int_block            (split_int_block)
        );

        // Synchronize, mask, prioritize.
        int_pending u_int_pending
        (
                .i_clk           (i_clk),
                .i_reset         (i_reset),
                .i_fiq           (i_fiq),
                .i_irq           (i_irq),
                .i_cpsr_fiq_mask (i_cpsr_fiq_mask),
                .i_cpsr_irq_mask (i_cpsr_irq_mask),
                .o_pend_fiq      (pend_fiq),
                .o_pend_irq      (pend_irq)
        );

        // Output register for the decoder.
        decode_latch u_decode_latch
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_clear_from_alu       (i_clear_from_alu),
                .i_stall_from_issue     (i_stall_from_issue),
                .i_instruction          (split_instruction),
                .i_instruction_valid    (split_valid),
                .i_int_block            (split_int_block),
                .i_pend_fiq             (pend_fiq),
                .i_pend_irq             (pend_irq),
                .o_instruction          (o_instruction),
                .o_instruction_valid    (o_instruction_valid),
                .o_op_class             (o_op_class),
                .o_fiq                  (o_fiq),
                .o_irq                  (o_irq)
        );

endmodule

// ==== verif/decode_frontend_assert.sv ====
module decode_frontend_assert
(
        input logic                  i_clk,
        input logic                  i_reset,

        // Splitter side.
        input decode_pkg::bl_state_t i_state,
        input logic                  i_stall_from_decode,
        input logic                  i_int_block,

        // Latch side.
        input logic                  i_clear,
        input logic                  i_instruction_valid,
        input logic                  i_fiq,
        input logic                  i_irq
);

        timeunit 1ns;
        timeprecision 100ps;

        import decode_pkg::*;

        // Fetch stall lasts a single cycle.
        stall_single_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
                i_stall_from_decode |=> !i_stall_from_decode)
                else $error("Stall from decode held for two cycles");

        // Second half of a split blocks interrupts.
        block_in_branch: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_state == S_BRANCH) |-> i_int_block)
                else $error("Interrupt block low in S_BRANCH");

        // FIQ priority leaves at most one line high.
        one_interrupt: assert property (@(posedge i_clk) disable iff (i_reset)
                !(i_fiq && i_irq))
                else $error("FIQ and IRQ high together");

        // Flushed slot is empty.
        clear_drops_valid: assert property (@(posedge i_clk) disable iff (i_reset)
                i_clear |=> !i_instruction_valid)
                else $error("Valid high in the cycle after a clear");

endmodule

// ==== verif/decode_frontend_tb.sv ====
module decode_frontend_tb;

        timeunit 1ns;
        timeprecision 100ps;

        import decode_pkg::*;

        // DUT inputs.
        logic               i_clk = 1'b0;
        logic               i_reset;
        logic               i_fiq;
        logic               i_irq;
        logic               i_cpsr_fiq_mask;
        logic               i_cpsr_irq_mask;
        logic               i_clear_from_writeback;
        logic               i_clear_from_alu;
        logic               i_stall_from_issue;
        logic [INSTR_W-1:0] i_instruction;
        logic               i_instruction_valid;

        // DUT outputs.
        logic [INSTR_W-1:0] o_instruction;
        logic               o_instruction_valid;
        op_class_t          o_op_class;
        logic               o_stall_from_decode;
        logic               o_fiq;
        logic               o_irq;

        // Stimulus columns with one entry per row.
        logic [INSTR_W-1:0] row_instr [$];
        logic               row_valid [$];
        logic               row_clr_wb [$];
        logic               row_clr_alu [$];
        logic               row_stall [$];
        logic               row_fiq [$];
        logic               row_irq [$];
        logic               row_fmask [$];
        logic               row_imask [$];

        // Expected columns.
        // Latch outputs lag the inputs by one row.
        logic [INSTR_W-1:0] exp_instr [$];
        logic               exp_valid [$];
        op_class_t          exp_class [$];
        logic               exp_stall [$];
        logic               exp_fiq [$];
        logic               exp_irq [$];

        // Interrupt levels that persist across rows.
        logic               fiq_level;
        logic               irq_level;
        logic               fiq_mask;
        logic               irq_mask;

        int                 cur_row;

        // Random instruction words.
        logic [INSTR_W-1:0] w_d;
        logic [INSTR_W-1:0] w_d2;
        logic [INSTR_W-1:0] w_m;
        logic [INSTR_W-1:0] w_b;
        logic [INSTR_W-1:0] w_o;
        logic [INSTR_W-1:0] bl1;
        logic [INSTR_W-1:0] bl2;
        logic [INSTR_W-1:0] bl3;
        logic [INSTR_W-1:0] bl4;
        logic [INSTR_W-1:0] bl5;
        logic [INSTR_W-1:0] bl6;

        decode_frontend dut
        (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_fiq                  (i_fiq),
                .i_irq                  (i_irq),
                .i_cpsr_fiq_mask        (i_cpsr_fiq_mask),
                .i_cpsr_irq_mask        (i_cpsr_irq_mask),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_clear_from_alu       (i_clear_from_alu),
                .i_stall_from_issue     (i_stall_from_issue),
                .i_instruction          (i_instruction),
                .i_instruction_valid    (i_instruction_valid),
                .o_instruction          (o_instruction),
                .o_instruction_valid    (o_instruction_valid),
                .o_op_class             (o_op_class),
                .o_stall_from_decode    (o_stall_from_decode),
                .o_fiq                  (o_fiq),
                .o_irq                  (o_irq)
        );

        // Splitter side with latch signals tied off.
        bind bl_split_fsm decode_frontend_assert u_split_assert
        (
                .i_clk               (i_clk),
                .i_reset             (i_reset),
                .i_state             (state_ff),
                .i_stall_from_decode (o_stall_from_decode),
                .i_int_block         (o_int_block),
                .i_clear             (1'b0),
                .i_instruction_valid (1'b0),
                .i_fiq               (1'b0),
                .i_irq               (1'b0)
        );

        // Latch side with splitter signals tied off.
        bind decode_latch decode_frontend_assert u_latch_assert
        (
                .i_clk               (i_clk),
                .i_reset             (i_reset),
                .i_state             (decode_pkg::S_NORMAL),
                .i_stall_from_decode (1'b0),
                .i_int_block         (i_int_block),
                .i_clear             (i_clear_from_writeback | i_clear_from_alu),
                .i_instruction_valid (o_instruction_valid),
                .i_fiq               (o_fiq),
                .i_irq               (o_irq)
        );

        // 4 ns period.
        always #2 i_clk = ~i_clk;

        // Random word with a fixed opcode field and link bit.
        function automatic logic [INSTR_W-1:0] make_word(input logic [2:0] op, input logic link);
                logic [31:0]        lo;
                logic [31:0]        hi;
                logic [INSTR_W-1:0] w;
                lo        = $urandom();
                hi        = $urandom();
                w         = {hi[2:0], lo};
                w[27:25]  = op;
                w[24]     = link;
                return w;
        endfunction

        // First half of a BL is its condition over the fixed move.
        function automatic logic [INSTR_W-1:0] mov_half(input logic [INSTR_W-1:0] bl);
                return {3'b000, bl[31:28], 28'h1A0E00F};
        endfunction

        // Second half drops the link bit.
        function automatic logic [INSTR_W-1:0] branch_half(input logic [INSTR_W-1:0] bl);
                logic [INSTR_W-1:0] w;
                w     = bl;
                w[24] = 1'b0;
                return w;
        endfunction

        task automatic stage_inputs(input logic [INSTR_W-1:0] instr, input logic valid,
                                    input logic clr_wb, input logic clr_alu, input logic stall);
                row_instr.push_back(instr);
                row_valid.push_back(valid);
                row_clr_wb.push_back(clr_wb);
                row_clr_alu.push_back(clr_alu);
                row_stall.push_back(stall);
                row_fiq.push_back(fiq_level);
                row_irq.push_back(irq_level);
                row_fmask.push_back(fiq_mask);
                row_imask.push_back(irq_mask);
        endtask

        task automatic record_expected(input logic [INSTR_W-1:0] instr, input logic valid,
                                       input op_class_t cls, input logic stall,
                                       input logic fiq, input logic irq);
                exp_instr.push_back(instr);
                exp_valid.push_back(valid);
                exp_class.push_back(cls);
                exp_stall.push_back(stall);
                exp_fiq.push_back(fiq);
                exp_irq.push_back(irq);
        endtask

        // Valid word without clear or stall, plus its expected outputs.
        task automatic word_row(input logic [INSTR_W-1:0] instr,
                                input logic [INSTR_W-1:0] e_instr, input logic e_valid,
                                input op_class_t e_cls, input logic e_stall,
                                input logic e_fiq, input logic e_irq);
                stage_inputs(instr, 1'b1, 1'b0, 1'b0, 1'b0);
                record_expected(e_instr, e_valid, e_cls, e_stall, e_fiq, e_irq);
        endtask

        // Idle cycle plus its expected outputs.
        task automatic idle_row(input logic [INSTR_W-1:0] e_instr, input logic e_valid,
                                input op_class_t e_cls, input logic e_stall,
                                input logic e_fiq, input logic e_irq);
                stage_inputs('0, 1'b0, 1'b0, 1'b0, 1'b0);
                record_expected(e_instr, e_valid, e_cls, e_stall, e_fiq, e_irq);
        endtask

        task automatic check_value(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
                if (got !== exp)
                begin
                        $display("MISMATCH %s row %0d: got 0x%0h expected 0x%0h",
                                 name, cur_row, got, exp);
                        $display("Testbench failed");
                        $fatal(1, "stopped at first error");
                end
        endtask

        task automatic apply_row(input int k);
                i_instruction          = row_instr[k];
                i_instruction_valid    = row_valid[k];
                i_clear_from_writeback = row_clr_wb[k];
                i_clear_from_alu       = row_clr_alu[k];
                i_stall_from_issue     = row_stall[k];
                i_fiq                  = row_fiq[k];
                i_irq                  = row_irq[k];
                i_cpsr_fiq_mask        = row_fmask[k];
                i_cpsr_irq_mask        = row_imask[k];
        endtask

        task automatic check_row(input int k);
                cur_row = k;
                check_value("o_stall_from_decode", 64'(o_stall_from_decode), 64'(exp_stall[k]));
                check_value("o_instruction_valid", 64'(o_instruction_valid), 64'(exp_valid[k]));
                check_value("o_op_class", 64'(o_op_class), 64'(exp_class[k]));
                check_value("o_fiq", 64'(o_fiq), 64'(exp_fiq[k]));
                check_value("o_irq", 64'(o_irq), 64'(exp_irq[k]));
                // Payload only matters with a valid word.
                if (exp_valid[k])
                        check_value("o_instruction", 64'(o_instruction), 64'(exp_instr[k]));
        endtask

        // Outputs must reach their reset values.
        task automatic wait_reset_state();
                int cycles;
                cycles = 0;
                while (o_instruction_valid !== 1'b0 || o_op_class !== OP_OTHER ||
                       o_fiq !== 1'b0 || o_irq !== 1'b0 || o_stall_from_decode !== 1'b0)
                begin
                        if (cycles == 100)
                        begin
                                $display("Timeout: outputs did not settle after reset");
                                $display("Testbench failed");
                                $fatal(1, "reset wait timed out");
                        end
                        @(posedge i_clk);
                        #1;
                        cycles++;
                end
        endtask

        initial
        begin
                i_reset                = 1'b1;
                i_fiq                  = 1'b0;
                i_irq                  = 1'b0;
                i_cpsr_fiq_mask        = 1'b0;
                i_cpsr_irq_mask        = 1'b0;
                i_clear_from_writeback = 1'b0;
                i_clear_from_alu       = 1'b0;
                i_stall_from_issue     = 1'b0;
                i_instruction          = '0;
                i_instruction_valid    = 1'b0;
                fiq_level              = 1'b0;
                irq_level              = 1'b0;
                fiq_mask               = 1'b0;
                irq_mask               = 1'b0;
                cur_row                = 0;
                void'($urandom(32'h7994e2d2));

                w_d  = make_word(3'b001, 1'b1);
                w_d2 = make_word(3'b000, 1'b0);
                w_m  = make_word(3'b011, 1'b0);
                w_b  = make_word(3'b101, 1'b0);
                w_o  = make_word(3'b110, 1'b1);
                bl1  = make_word(3'b101, 1'b1);
                bl2  = make_word(3'b101, 1'b1);
                bl3  = make_word(3'b101, 1'b1);
                bl4  = make_word(3'b101, 1'b1);
                bl5  = make_word(3'b101, 1'b1);
                bl6  = make_word(3'b101, 1'b1);

                // Plain words of each class.
                word_row(w_d, '0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                word_row(w_m, w_d, 1'b1, OP_DATA, 1'b0, 1'b0, 1'b0);
                word_row(w_b, w_m, 1'b1, OP_MEM, 1'b0, 1'b0, 1'b0);
                word_row(w_o, w_b, 1'b1, OP_BRANCH, 1'b0, 1'b0, 1'b0);
                idle_row(w_o, 1'b1, OP_OTHER, 1'b0, 1'b0, 1'b0);

                // BL split with the word repeated once.
                word_row(bl1, '0, 1'b0, OP_DATA, 1'b1, 1'b0, 1'b0);
                word_row(bl1, mov_half(bl1), 1'b1, OP_DATA, 1'b0, 1'b0, 1'b0);
                idle_row(branch_half(bl1), 1'b1, OP_BRANCH, 1'b0, 1'b0, 1'b0);

                // IRQ takes three rows to appear.
                irq_level = 1'b1;
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                // Blocked while the split is in flight.
                word_row(bl2, '0, 1'b0, OP_DATA, 1'b1, 1'b0, 1'b1);
                word_row(bl2, mov_half(bl2), 1'b1, OP_DATA, 1'b0, 1'b0, 1'b0);
                idle_row(branch_half(bl2), 1'b1, OP_BRANCH, 1'b0, 1'b0, 1'b0);
                // IRQ mask set while the level drains.
                irq_mask = 1'b1;
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b1);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                irq_level = 1'b0;
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                irq_mask = 1'b0;
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);

                // FIQ wins over IRQ.
                fiq_level = 1'b1;
                irq_level = 1'b1;
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                // Masked FIQ lets IRQ through.
                fiq_mask = 1'b1;
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b1, 1'b0);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b1);
                fiq_mask  = 1'b0;
                fiq_level = 1'b0;
                irq_level = 1'b0;
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b1);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b1, 1'b0);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b1, 1'b0);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);

                // Issue stall in the second half of a split.
                word_row(w_d2, '0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);
                word_row(bl3, w_d2, 1'b1, OP_DATA, 1'b1, 1'b0, 1'b0);
                stage_inputs(bl3, 1'b1, 1'b0, 1'b0, 1'b1);
                record_expected(mov_half(bl3), 1'b1, OP_DATA, 1'b0, 1'b0, 1'b0);
                stage_inputs(bl3, 1'b1, 1'b0, 1'b0, 1'b1);
                record_expected(mov_half(bl3), 1'b1, OP_DATA, 1'b0, 1'b0, 1'b0);
                word_row(bl3, mov_half(bl3), 1'b1, OP_DATA, 1'b0, 1'b0, 1'b0);
                idle_row(branch_half(bl3), 1'b1, OP_BRANCH, 1'b0, 1'b0, 1'b0);

                // ALU clear mid-split so the next BL starts over.
                word_row(bl4, '0, 1'b0, OP_DATA, 1'b1, 1'b0, 1'b0);
                stage_inputs(bl4, 1'b1, 1'b0, 1'b1, 1'b0);
                record_expected(mov_half(bl4), 1'b1, OP_DATA, 1'b0, 1'b0, 1'b0);
                word_row(bl5, '0, 1'b0, OP_OTHER, 1'b1, 1'b0, 1'b0);
                word_row(bl5, mov_half(bl5), 1'b1, OP_DATA, 1'b0, 1'b0, 1'b0);
                idle_row(branch_half(bl5), 1'b1, OP_BRANCH, 1'b0, 1'b0, 1'b0);

                // Writeback clear mid-split and the same BL fetched again.
                word_row(bl6, '0, 1'b0, OP_DATA, 1'b1, 1'b0, 1'b0);
                stage_inputs(bl6, 1'b1, 1'b1, 1'b0, 1'b0);
                record_expected(mov_half(bl6), 1'b1, OP_DATA, 1'b0, 1'b0, 1'b0);
                word_row(bl6, '0, 1'b0, OP_OTHER, 1'b1, 1'b0, 1'b0);
                word_row(bl6, mov_half(bl6), 1'b1, OP_DATA, 1'b0, 1'b0, 1'b0);
                idle_row(branch_half(bl6), 1'b1, OP_BRANCH, 1'b0, 1'b0, 1'b0);
                idle_row('0, 1'b0, OP_DATA, 1'b0, 1'b0, 1'b0);

                // Reset for five edges.
                repeat (5) @(posedge i_clk);
                #1;
                i_reset = 1'b0;
                wait_reset_state();

                // Drive 1 ns after the edge and sample 1 ns later.
                for (int k = 0; k < row_instr.size(); k++)
                begin
                        @(posedge i_clk);
                        #1;
                        apply_row(k);
                        #1;
                        check_row(k);
                end

                $display("Testbench passed");
                $finish;
        end

endmodule

// ==== src.f ====
verilog/decode_pkg.sv
verilog/bl_split_fsm.sv
verilog/int_pending.sv
verilog/decode_latch.sv
verilog/decode_frontend.sv
verif/decode_frontend_assert.sv
verif/decode_frontend_tb.sv

// ==== Makefile ====
TOP := decode_frontend_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) \
		-Mdir $(OBJ) -o V$(TOP)

run: compile
	./$(OBJ)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)
